// ==== source/tcp_rx_pkg.sv ====
package tcp_rx_pkg;

  // ip protocol number for tcp
  localparam logic [7:0]  PROTO_TCP   = 8'd6;
  // fixed header size in bytes, without options
  localparam logic [15:0] TCP_HDR_LEN = 16'd20;
  // byte index of the data offset nibble
  localparam logic [15:0] TCP_OFF_POS = 16'd12;

  // byte stream from the ipv4 layer, first byte is the first tcp byte
  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
  } ip_strm_t;

  // decoded ipv4 fields, stable from sof to eof
  typedef struct packed {
    logic [7:0]  proto;
    logic [15:0] pld_len;
  } ip_meta_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq;
    logic [31:0] ack;
    logic [3:0]  data_offset;
    logic [2:0]  rsvd;
    logic [8:0]  flags;
    logic [15:0] wnd;
    logic [15:0] checksum;
    logic [15:0] urg_ptr;
  } tcp_hdr_t;

  typedef struct packed {
    logic        mss_pres;
    logic [15:0] mss;
    logic        wnd_pres;
    logic [7:0]  wnd_scale;
    logic        sack_perm_pres;
    logic        sack_pres;
    logic [2:0]  sack_blocks;
    logic        ts_pres;
    logic [31:0] ts_val;
    logic [31:0] ts_ecr;
  } tcp_opt_t;

  typedef enum logic {kind_opt, kind_pld} byte_kind_e;

  // a last beat with val low closes a segment that carries no option or payload byte
  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    byte_kind_e kind;
    logic       last;
  } tcp_beat_t;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
  } tcp_strm_t;

  typedef struct packed {
    tcp_hdr_t    hdr;
    tcp_opt_t    opt;
    logic [15:0] pld_len;
  } tcp_meta_t;

  typedef enum logic [1:0] {field_kind, field_len, field_data} opt_field_e;

  typedef enum logic [7:0] {
    opt_end       = 8'd0,
    opt_nop       = 8'd1,
    opt_mss       = 8'd2,
    opt_wnd       = 8'd3,
    opt_sack_perm = 8'd4,
    opt_sack      = 8'd5,
    opt_timestamp = 8'd8
  } opt_kind_e;

endpackage : tcp_rx_pkg

// ==== source/tcp_hdr_stage.sv ====
`timescale 1ns/1ps

module tcp_hdr_stage import tcp_rx_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  ip_strm_t  strm,
  input  ip_meta_t  meta,
  output tcp_beat_t beat,
  output tcp_hdr_t  hdr
);

  typedef enum logic [1:0] {idle_s, header_s, body_s, drop_s} state_e;

  state_e           state;
  logic [15:0]      cnt;
  logic [15:0]      len;
  logic [5:0]       off_bytes;
  logic [18:0][7:0] sr;
  logic [3:0]       off_words;
  logic             bad_off;

  // data offset sits in the upper nibble of byte 12
  assign off_words = strm.dat[7:4];
  assign bad_off   = (off_words < 4'd5) || ({10'd0, off_words, 2'b00} > len);

  // cnt holds the index of the byte on the input in every state but idle
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state <= idle_s;
      cnt   <= '0;
      beat  <= '0;
    end else begin
      beat.val  <= 1'b0;
      beat.last <= 1'b0;
      if (strm.val) begin
        case (state)
          idle_s: begin
            cnt <= 16'd1;
            if (strm.sof && meta.proto == PROTO_TCP) begin
              state <= header_s;
            end else if (strm.sof && !strm.eof) begin
              state <= drop_s;
            end
          end
          header_s: begin
            cnt <= cnt + 16'd1;
            if (cnt == TCP_OFF_POS && bad_off) begin
              state <= drop_s;
            end else if (cnt == TCP_HDR_LEN - 16'd1) begin
              if (len == TCP_HDR_LEN) begin
                // header only, close the segment without a byte
                beat.last <= 1'b1;
                state     <= idle_s;
              end else begin
                state <= body_s;
              end
            end
          end
          body_s: begin
            cnt       <= cnt + 16'd1;
            beat.val  <= 1'b1;
            beat.dat  <= strm.dat;
            beat.kind <= (cnt < {10'd0, off_bytes}) ? kind_opt : kind_pld;
            beat.last <= (cnt == len - 16'd1);
            if (cnt == len - 16'd1 || strm.eof) begin
              state <= idle_s;
            end
          end
          drop_s: begin
            if (strm.eof) begin
              state <= idle_s;
            end
          end
          default: state <= idle_s;
        endcase
      end
    end
  end

  // header shift register and per segment fields
  always_ff @(posedge clk) begin
    if (strm.val) begin
      sr <= {sr[17:0], strm.dat};
      if (state == idle_s && strm.sof) begin
        len <= meta.pld_len;
      end
      if (state == header_s && cnt == TCP_OFF_POS) begin
        off_bytes <= {off_words, 2'b00};
      end
      if (state == header_s && cnt == TCP_HDR_LEN - 16'd1) begin
        hdr <= {sr, strm.dat};
      end
    end
  end

  // filtered and dropped frames never reach the next stage
  a_no_beat_idle_drop: assert property (@(posedge clk) disable iff (fsm_rst)
    (state == idle_s || state == drop_s) |=> !beat.val);

endmodule : tcp_hdr_stage

// ==== source/tcp_opt_stage.sv ====
`timescale 1ns/1ps

module tcp_opt_stage import tcp_rx_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  tcp_beat_t beat_in,
  input  tcp_hdr_t  hdr_in,
  output tcp_beat_t beat,
  output tcp_hdr_t  hdr_q,
  output tcp_opt_t  opt
);

  opt_field_e  field;
  opt_kind_e   cur_kind;
  logic [7:0]  rem;
  logic [55:0] sr;
  logic        opt_done;
  logic        opt_byte;

  // option bytes are only decoded until an end option shows up
  assign opt_byte = beat_in.val && (beat_in.kind == kind_opt) && !opt_done;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      beat     <= '0;
      field    <= field_kind;
      cur_kind <= opt_nop;
      rem      <= '0;
      opt_done <= 1'b0;
      opt      <= '0;
    end else begin
      beat <= beat_in;
      // last beat has gone on, start clean for the next segment
      if (beat.last) begin
        field    <= field_kind;
        opt_done <= 1'b0;
        opt      <= '0;
      end
      if (opt_byte) begin
        case (field)
          field_kind: begin
            field <= field_len;
            case (beat_in.dat)
              opt_end: begin
                opt_done <= 1'b1;
                field    <= field_kind;
              end
              opt_mss: begin
                opt.mss_pres <= 1'b1;
                cur_kind     <= opt_mss;
              end
              opt_wnd: begin
                opt.wnd_pres <= 1'b1;
                cur_kind     <= opt_wnd;
              end
              opt_sack_perm: begin
                opt.sack_perm_pres <= 1'b1;
                cur_kind           <= opt_sack_perm;
              end
              opt_sack: begin
                opt.sack_pres <= 1'b1;
                cur_kind      <= opt_sack;
              end
              opt_timestamp: begin
                opt.ts_pres <= 1'b1;
                cur_kind    <= opt_timestamp;
              end
              // nop and unknown kinds are one byte long
              default: field <= field_kind;
            endcase
          end
          field_len: begin
            rem   <= beat_in.dat - 8'd2;
            field <= (beat_in.dat > 8'd2) ? field_data : field_kind;
            // sack length is 2 plus 8 bytes per block
            if (cur_kind == opt_sack) begin
              case (beat_in.dat)
                8'd10:   opt.sack_blocks <= 3'd1;
                8'd18:   opt.sack_blocks <= 3'd2;
                8'd26:   opt.sack_blocks <= 3'd3;
                8'd34:   opt.sack_blocks <= 3'd4;
                default: opt.sack_blocks <= 3'd0;
              endcase
            end
          end
          field_data: begin
            rem <= rem - 8'd1;
            sr  <= {sr[47:0], beat_in.dat};
            if (rem == 8'd1) begin
              field <= field_kind;
              case (cur_kind)
                opt_mss:       opt.mss <= {sr[7:0], beat_in.dat};
                opt_wnd:       opt.wnd_scale <= beat_in.dat;
                opt_timestamp: {opt.ts_val, opt.ts_ecr} <= {sr, beat_in.dat};
                default:       ;
              endcase
            end
          end
          default: field <= field_kind;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    hdr_q <= hdr_in;
  end

  a_data_has_len: assert property (@(posedge clk) disable iff (fsm_rst)
    (field == field_data) |-> (rem != 8'd0));

endmodule : tcp_opt_stage

// ==== source/tcp_pld_stage.sv ====
`timescale 1ns/1ps

module tcp_pld_stage import tcp_rx_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  tcp_beat_t beat_in,
  input  tcp_hdr_t  hdr_in,
  input  tcp_opt_t  opt_in,
  output tcp_strm_t tcp_strm,
  output tcp_meta_t tcp_meta,
  output logic      meta_val
);

  logic [15:0] pld_cnt;
  logic [15:0] pld_len;
  logic        pld_beat;

  assign pld_beat = beat_in.val && (beat_in.kind == kind_pld);
  // on the last beat this equals the ipv4 length minus the offset bytes
  assign pld_len  = pld_cnt + {15'd0, pld_beat};

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tcp_strm <= '0;
      meta_val <= 1'b0;
      pld_cnt  <= '0;
    end else begin
      tcp_strm.dat <= beat_in.dat;
      tcp_strm.val <= pld_beat;
      tcp_strm.sof <= pld_beat && (pld_cnt == 16'd0);
      tcp_strm.eof <= pld_beat && beat_in.last;
      // segment end, payload or not
      meta_val     <= beat_in.last;
      if (beat_in.last) begin
        pld_cnt <= '0;
      end else if (pld_beat) begin
        pld_cnt <= pld_len;
      end
    end
  end

  // record is held until the next segment closes
  always_ff @(posedge clk) begin
    if (beat_in.last) begin
      tcp_meta <= '{hdr: hdr_in, opt: opt_in, pld_len: pld_len};
    end
  end

  a_marks_need_val: assert property (@(posedge clk) disable iff (fsm_rst)
    (tcp_strm.sof || tcp_strm.eof) |-> tcp_strm.val);

  a_meta_val_pulse: assert property (@(posedge clk) disable iff (fsm_rst)
    meta_val |=> !meta_val);

endmodule : tcp_pld_stage

// ==== source/tcp_rx_top.sv ====
`timescale 1ns/1ps

module tcp_rx_top import tcp_rx_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  ip_strm_t  strm,
  input  ip_meta_t  meta,
  output tcp_strm_t tcp_strm,
  output tcp_meta_t tcp_meta,
  output logic      meta_val
);

  tcp_beat_t hdr_beat;
  tcp_beat_t opt_beat;
  tcp_hdr_t  hdr;
  tcp_hdr_t  hdr_q;
  tcp_opt_t  opt;

  // filter, header capture and byte tagging
  tcp_hdr_stage i_tcp_hdr_stage (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .strm    (strm),
    .meta    (meta),
    .beat    (hdr_beat),
    .hdr     (hdr)
  );

  tcp_opt_stage i_tcp_opt_stage (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .beat_in (hdr_beat),
    .hdr_in  (hdr),
    .beat    (opt_beat),
    .hdr_q   (hdr_q),
    .opt     (opt)
  );

  tcp_pld_stage i_tcp_pld_stage (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .beat_in  (opt_beat),
    .hdr_in   (hdr_q),
    .opt_in   (opt),
    .tcp_strm (tcp_strm),
    .tcp_meta (tcp_meta),
    .meta_val (meta_val)
  );

endmodule : tcp_rx_top

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

endmodule : tb_clock_gen

// ==== test/tcp_rx_checker.sv ====
`timescale 1ns/1ps

module tcp_rx_checker import tcp_rx_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  ip_strm_t  strm,
  input  ip_meta_t  meta,
  input  tcp_strm_t tcp_strm,
  input  tcp_meta_t tcp_meta,
  input  logic      meta_val,
  output logic      busy
);

  typedef struct packed {
    logic        ok;
    tcp_meta_t   meta;
  } ref_t;

  typedef struct packed {
    logic [7:0]  dat;
    logic        sof;
    logic        eof;
    logic [31:0] cyc;
  } pld_exp_t;

  logic [7:0]  frm [0:255];
  tcp_meta_t   exp_meta[$];
  logic        exp_has_pld[$];
  pld_exp_t    exp_pld[$];
  pld_exp_t    p;
  tcp_meta_t   em;
  ref_t        r;
  logic        hp;
  logic [15:0] off;
  int          n;
  int          cyc = 0;
  int          test_err = 0;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          fail_cnt = 0;

  // expected record for one frame, straight from the tcp header and option layout
  function automatic ref_t ref_seg(input ip_meta_t m);
    ref_t         rr;
    int           i;
    int           off_b;
    logic [7:0]   k;
    logic [7:0]   l;
    logic [159:0] h;
    logic         done;
    rr = '0;
    off_b = frm[12][7:4] * 4;
    if (m.proto != PROTO_TCP || off_b < 20 || off_b > m.pld_len) begin
      return rr;
    end
    rr.ok = 1'b1;
    for (i = 0; i < 20; i++) begin
      h = {h[151:0], frm[i]};
    end
    rr.meta.hdr     = h;
    rr.meta.pld_len = m.pld_len - off_b;
    i = 20;
    done = 1'b0;
    while (i < off_b && !done) begin
      k = frm[i];
      l = frm[i + 1];
      if (k == 8'd0) begin
        done = 1'b1;
      end else if (k == 8'd2 || k == 8'd3 || k == 8'd4 || k == 8'd5 || k == 8'd8) begin
        case (k)
          8'd2: begin
            rr.meta.opt.mss_pres = 1'b1;
            rr.meta.opt.mss      = {frm[i + 2], frm[i + 3]};
          end
          8'd3: begin
            rr.meta.opt.wnd_pres  = 1'b1;
            rr.meta.opt.wnd_scale = frm[i + 2];
          end
          8'd4: rr.meta.opt.sack_perm_pres = 1'b1;
          8'd5: begin
            rr.meta.opt.sack_pres   = 1'b1;
            rr.meta.opt.sack_blocks = (l == 10) ? 3'd1 : (l == 18) ? 3'd2 :
                                      (l == 26) ? 3'd3 : (l == 34) ? 3'd4 : 3'd0;
          end
          default: begin
            rr.meta.opt.ts_pres = 1'b1;
            rr.meta.opt.ts_val  = {frm[i + 2], frm[i + 3], frm[i + 4], frm[i + 5]};
            rr.meta.opt.ts_ecr  = {frm[i + 6], frm[i + 7], frm[i + 8], frm[i + 9]};
          end
        endcase
        i = i + ((l > 2) ? l : 2);
      end else begin
        // nop and unknown kinds
        i = i + 1;
      end
    end
    return rr;
  endfunction

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (fsm_rst) begin
      n = 0;
    end else begin
      // input side, payload bytes are known once byte 12 is in
      if (strm.val) begin
        if (strm.sof) begin
          n = 0;
        end
        frm[n] = strm.dat;
        if (n == 12) begin
          off = {10'd0, strm.dat[7:4], 2'b00};
        end
        if (n >= 20 && meta.proto == PROTO_TCP && off >= 20 && off <= meta.pld_len &&
            n >= off) begin
          exp_pld.push_back('{strm.dat, n == off, n == meta.pld_len - 1, cyc});
        end
        if (strm.eof) begin
          r = ref_seg(meta);
          if (r.ok) begin
            exp_meta.push_back(r.meta);
            exp_has_pld.push_back(r.meta.pld_len != 0);
          end
        end
        n = n + 1;
      end
      // output side
      if (tcp_strm.val) begin
        if (exp_pld.size() == 0) begin
          $display("payload byte 0x%02h came out at %0t with none expected", tcp_strm.dat,
                   $time);
          test_err++;
        end else begin
          p = exp_pld.pop_front();
          if (tcp_strm.dat != p.dat || tcp_strm.sof != p.sof || tcp_strm.eof != p.eof) begin
            $display("error at %0t: payload beat %h/%b/%b, expected %h/%b/%b", $time,
                     tcp_strm.dat, tcp_strm.sof, tcp_strm.eof, p.dat, p.sof, p.eof);
            test_err++;
          end
          if (cyc != p.cyc + 3) begin
            $display("error at %0t: payload latency %0d cycles, expected 3", $time,
                     cyc - p.cyc);
            test_err++;
          end
        end
      end
      if (meta_val) begin
        if (exp_meta.size() == 0) begin
          $display("meta_val pulsed at %0t with no segment pending", $time);
          test_err++;
        end else begin
          em = exp_meta.pop_front();
          hp = exp_has_pld.pop_front();
          if (tcp_meta !== em) begin
            $display("error at %0t: tcp_meta %h, expected %h", $time, tcp_meta, em);
            test_err++;
          end
          if (hp != tcp_strm.eof) begin
            $display("error at %0t: meta_val and eof not aligned", $time);
            test_err++;
          end
        end
      end else if (tcp_strm.eof) begin
        $display("error at %0t: eof without meta_val", $time);
        test_err++;
      end
    end
    busy <= (exp_meta.size() != 0) || (exp_pld.size() != 0);
  end

  task end_test(input string name);
    if (exp_meta.size() != 0) begin
      $display("%s: meta_val never came for %0d segment(s)", name, exp_meta.size());
      test_err++;
      exp_meta.delete();
      exp_has_pld.delete();
    end
    if (exp_pld.size() != 0) begin
      $display("%s: %0d payload byte(s) never came out", name, exp_pld.size());
      test_err++;
      exp_pld.delete();
    end
    test_cnt++;
    if (test_err != 0) begin
      fail_cnt++;
    end
    $display("test %s: %s (%0d errors)", name, (test_err != 0) ? "failed" : "passed",
             test_err);
    err_cnt  = err_cnt + test_err;
    test_err = 0;
  endtask

  task final_report();
    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
  endtask

endmodule : tcp_rx_checker

// ==== test/tb_tcp_rx.sv ====
`timescale 1ns/1ps

module tb_tcp_rx import tcp_rx_pkg::*;;

  // upper bound on the stimulus bytes of all tests with 100 per random segment
  localparam int MAX_BYTES = 4400;

  logic       clk;
  logic       fsm_rst;
  logic       busy;
  ip_strm_t   strm;
  ip_meta_t   meta;
  tcp_strm_t  tcp_strm;
  tcp_meta_t  tcp_meta;
  logic       meta_val;
  logic [7:0] frame[$];
  integer     seed;

  tb_clock_gen i_clk_gen (.clk(clk));

  tcp_rx_top i_tcp_rx_top (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .strm     (strm),
    .meta     (meta),
    .tcp_strm (tcp_strm),
    .tcp_meta (tcp_meta),
    .meta_val (meta_val)
  );

  tcp_rx_checker i_checker (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .strm     (strm),
    .meta     (meta),
    .tcp_strm (tcp_strm),
    .tcp_meta (tcp_meta),
    .meta_val (meta_val),
    .busy     (busy)
  );

  // mask bits select mss, nop+wscale, sack-permitted, sack and nop+nop+timestamp
  task automatic build_seg(input logic [4:0] mask, input int sack_len, input int pld_n);
    logic [7:0] opts[$];
    int         i;
    frame.delete();
    if (mask[0]) opts = {opts, 8'd2, 8'd4, 8'($random(seed)), 8'($random(seed))};
    if (mask[1]) opts = {opts, 8'd1, 8'd3, 8'd3, 8'($random(seed))};
    if (mask[2]) opts = {opts, 8'd4, 8'd2};
    if (mask[3]) begin
      opts = {opts, 8'd5, 8'(sack_len)};
      for (i = 0; i < sack_len - 2; i++) opts.push_back(8'($random(seed)));
    end
    if (mask[4]) begin
      opts = {opts, 8'd1, 8'd1, 8'd8, 8'd10};
      for (i = 0; i < 8; i++) opts.push_back(8'($random(seed)));
    end
    if (mask != 0) opts.push_back(8'd0);
    while (opts.size() % 4 != 0) opts.push_back(8'd0);
    for (i = 0; i < 20; i++) frame.push_back(8'($random(seed)));
    frame[12] = {4'((20 + opts.size()) / 4), frame[12][3:0]};
    frame = {frame, opts};
    for (i = 0; i < pld_n; i++) frame.push_back(8'($random(seed)));
  endtask

  task automatic send_frame(input logic [7:0] proto, input bit gaps);
    for (int i = 0; i < frame.size(); i++) begin
      if (gaps && ($random(seed) & 3) == 0) begin
        @(posedge clk);
        strm.val <= 1'b0;
      end
      @(posedge clk);
      strm <= '{dat: frame[i], val: 1'b1, sof: i == 0, eof: i == frame.size() - 1};
      meta <= '{proto: proto, pld_len: 16'(frame.size())};
    end
    @(posedge clk);
    strm <= '0;
  endtask

  // let the pipeline empty with a bounded wait for a missing meta_val
  task automatic drain(input string name);
    int n;
    n = 0;
    repeat (2) @(posedge clk);
    while (busy && n < 40) begin
      @(posedge clk);
      n++;
    end
    repeat (4) @(posedge clk);
    // close the test between edges, after the last compare
    @(negedge clk);
    i_checker.end_test(name);
  endtask

  initial begin
    seed    = 32'h1d07;
    fsm_rst = 1'b1;
    strm    = '0;
    meta    = '0;
    repeat (10) @(posedge clk);
    fsm_rst <= 1'b0;
    build_seg(5'b00000, 0, 16);
    send_frame(PROTO_TCP, 1'b0);
    drain("header_and_payload");
    build_seg(5'b10011, 0, 12);
    send_frame(PROTO_TCP, 1'b0);
    drain("options_and_payload");
    build_seg(5'b01100, 18, 0);
    send_frame(PROTO_TCP, 1'b0);
    drain("sack_zero_payload");
    build_seg(5'b00000, 0, 8);
    send_frame(8'd17, 1'b0);
    build_seg(5'b00000, 0, 8);
    frame[12] = 8'h40;
    send_frame(PROTO_TCP, 1'b0);
    drain("dropped_frames");
    for (int t = 0; t < 40; t++) begin
      build_seg(5'($random(seed)), 10, $unsigned($random(seed)) % 41);
      send_frame(PROTO_TCP, 1'b1);
    end
    drain("random_segments");
    build_seg(5'b00001, 0, 24);
    send_frame(PROTO_TCP, 1'b0);
    drain("payload_latency");
    i_checker.final_report();
    if (i_checker.err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((MAX_BYTES * 4 + 200) * 40);
    $display("run timed out before all tests finished");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule : tb_tcp_rx

// ==== flist.f ====
source/tcp_rx_pkg.sv
source/tcp_hdr_stage.sv
source/tcp_opt_stage.sv
source/tcp_pld_stage.sv
source/tcp_rx_top.sv
test/tb_clock_gen.sv
test/tcp_rx_checker.sv
test/tb_tcp_rx.sv

// ==== Bender.yml ====
package:
  name: tcp_rx

sources:
  - source/tcp_rx_pkg.sv
  - source/tcp_hdr_stage.sv
  - source/tcp_opt_stage.sv
  - source/tcp_pld_stage.sv
  - source/tcp_rx_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tcp_rx_checker.sv
      - test/tb_tcp_rx.sv
